// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = StageEX_tb
FLIST     = flist.f
OBJDIR    = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== common/Types.sv ====
package Types;

    // ----------------------------------------------------------------------
    // Datapath widths
    // ----------------------------------------------------------------------

    localparam int DATA_WIDTH     = 32;   // RV32I word
    localparam int ADDR_WIDTH     = 32;   // PC width
    localparam int CSR_ADDR_WIDTH = 12;   // CSR address space

    typedef logic [DATA_WIDTH-1:0]     Data;       // Register data word
    typedef logic [ADDR_WIDTH-1:0]     InstAddr;   // Instruction address
    typedef logic [CSR_ADDR_WIDTH-1:0] CSRAddr;    // CSR address

    // ----------------------------------------------------------------------
    // CSR addresses
    // ----------------------------------------------------------------------

    // Machine registers, read-write
    localparam CSRAddr CSR_MTVEC    = 12'h305;  // Trap vector base
    localparam CSRAddr CSR_MSCRATCH = 12'h340;  // Scratch for trap handlers
    localparam CSRAddr CSR_MEPC     = 12'h341;  // Exception PC

    // User counters, read only
    localparam CSRAddr CSR_CYCLE    = 12'hC00;  // Cycle count, low half
    localparam CSRAddr CSR_INSTRET  = 12'hC02;  // Retired count, low half
    localparam CSRAddr CSR_CYCLEH   = 12'hC80;  // Cycle count, high half
    localparam CSRAddr CSR_INSTRETH = 12'hC82;  // Retired count, high half

    // ----------------------------------------------------------------------
    // Selects and operations
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        DataASel_RS1,     // Register RS1
        DataASel_IMM,     // Immediate
        DataASel_ZERO,    // Constant zero, for LUI
        DataASel_PC       // PC, for AUIPC and JAL
    } DataASel;

    typedef enum logic [1:0] {
        DataBSel_RS2,     // Register RS2
        DataBSel_IMM,     // Immediate
        DataBSel_FOUR     // Constant four, link address
    } DataBSel;

    typedef enum logic {
        ResultSel_ALU,    // ALU result
        ResultSel_CSR     // CSR old value
    } ResultSel;

    typedef enum logic [3:0] {
        AluOp_ADD,
        AluOp_SUB,
        AluOp_SLL,
        AluOp_SLT,        // Signed compare
        AluOp_SLTU,       // Unsigned compare
        AluOp_XOR,
        AluOp_SRL,
        AluOp_SRA,        // Sign-filling shift
        AluOp_OR,
        AluOp_AND
    } AluOp;

    typedef enum logic [1:0] {
        CsrOp_NOP,        // No access side effect
        CsrOp_RW,         // Read and write
        CsrOp_RS,         // Read and set bits
        CsrOp_RC          // Read and clear bits
    } CsrOp;

endpackage

// ==== design/ALU.sv ====
module ALU (
    input  Types::AluOp i_op,      // Operation
    input  Types::Data  i_dataA,   // Operand A
    input  Types::Data  i_dataB,   // Operand B
    output Types::Data  o_result); // Result

    import Types::*;

    // ----------------------------------------------------------------------
    // Shift amount and compares
    // ----------------------------------------------------------------------

    logic [4:0] shamt;      // RV32I uses five bits of B
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = i_dataB[4:0];
    assign lessSigned   = $signed(i_dataA) < $signed(i_dataB);
    assign lessUnsigned = i_dataA < i_dataB;

    // ----------------------------------------------------------------------
    // Operation select
    // ----------------------------------------------------------------------

    Data result;

    always_comb begin
        case (i_op)
            AluOp_ADD:  result = i_dataA + i_dataB;
            AluOp_SUB:  result = i_dataA - i_dataB;
            AluOp_SLL:  result = i_dataA << shamt;
            AluOp_SLT:  result = Data'(lessSigned);     // 1 or 0
            AluOp_SLTU: result = Data'(lessUnsigned);   // 1 or 0
            AluOp_XOR:  result = i_dataA ^ i_dataB;
            AluOp_SRL:  result = i_dataA >> shamt;      // Zero fill
            AluOp_SRA:  result = Data'($signed(i_dataA) >>> shamt);
            AluOp_OR:   result = i_dataA | i_dataB;
            AluOp_AND:  result = i_dataA & i_dataB;
            default:    result = '0;                    // Unused encodings
        endcase
    end

    assign o_result = result;

endmodule

// ==== design/StageEX.sv ====
module StageEX #(
    parameter int COUNTER_WIDTH = 64)       // CSR counter width
(
    // Control
    input  logic            i_clock,        // Clock
    input  logic            i_reset,        // Synchronous reset

    // Operation of this slot
    input  logic            i_isValid,      // Slot holds a real instruction
    input  Types::Data      i_instIMM,      // Immediate value
    input  Types::CSRAddr   i_instCSR,      // CSR address field
    input  Types::Data      i_dataRS1,      // X[RS1]
    input  Types::Data      i_dataRS2,      // X[RS2]
    input  Types::InstAddr  i_pc,           // Instruction address
    input  Types::DataASel  i_operandASel,  // Operand A source
    input  Types::DataBSel  i_operandBSel,  // Operand B source
    input  Types::ResultSel i_resultSel,    // Result source
    input  Types::AluOp     i_aluControl,   // ALU operation
    input  Types::CsrOp     i_csrControl,   // CSR operation
    input  logic            i_instRet,      // Instruction retired
    output Types::Data      o_dataR,        // Result
    output Types::Data      o_dataB);       // Store data

    import Types::*;

    // ----------------------------------------------------------------------
    // Operand selection
    // ----------------------------------------------------------------------

    Data operandA;
    Data operandB;

    always_comb begin
        case (i_operandASel)
            DataASel_RS1:  operandA = i_dataRS1;
            DataASel_IMM:  operandA = i_instIMM;
            DataASel_ZERO: operandA = '0;
            DataASel_PC:   operandA = Data'(i_pc);
            default:       operandA = '0;
        endcase
    end

    always_comb begin
        case (i_operandBSel)
            DataBSel_RS2:  operandB = i_dataRS2;
            DataBSel_IMM:  operandB = i_instIMM;
            DataBSel_FOUR: operandB = Data'(4);     // Link offset
            default:       operandB = '0;           // Unused encoding
        endcase
    end

    // ----------------------------------------------------------------------
    // CSR unit
    // ----------------------------------------------------------------------

    CsrOp csrOp;
    Data  csrUnit_data;

    // Bubbles still read but never write
    assign csrOp = i_isValid ? i_csrControl : CsrOp_NOP;

    CSRUnit #(
        .COUNTER_WIDTH (COUNTER_WIDTH))
    csrUnit (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_instRet (i_instRet),
        .i_op      (csrOp),
        .i_csr     (i_instCSR),
        .i_data    (operandA),      // RS1 or zimm through A
        .o_data    (csrUnit_data));

    // ----------------------------------------------------------------------
    // Integer ALU
    // ----------------------------------------------------------------------

    Data aluUnit_result;

    ALU
    aluUnit (
        .i_op     (i_aluControl),
        .i_dataA  (operandA),
        .i_dataB  (operandB),
        .o_result (aluUnit_result));

    // ----------------------------------------------------------------------
    // Result selection
    // ----------------------------------------------------------------------

    always_comb begin
        case (i_resultSel)
            ResultSel_CSR: o_dataR = csrUnit_data;
            default:       o_dataR = aluUnit_result;
        endcase
    end

    assign o_dataB = i_dataRS2;     // Passed on to memory stage

endmodule

// ==== design/csr/CSRUnit.sv ====
module CSRUnit #(
    parameter int COUNTER_WIDTH = 64)       // Counter width, 32 or 64
(
    input  logic          i_clock,    // Clock
    input  logic          i_reset,    // Synchronous reset
    input  logic          i_instRet,  // Instruction retired
    input  Types::CsrOp   i_op,       // CSR operation
    input  Types::CSRAddr i_csr,      // CSR address
    input  Types::Data    i_data,     // Write or mask operand
    output Types::Data    o_data);    // Old CSR value

    import Types::*;

    // ----------------------------------------------------------------------
    // Cycle and retired-instruction counters
    // ----------------------------------------------------------------------

    logic [COUNTER_WIDTH-1:0] counters_cycle;
    logic [COUNTER_WIDTH-1:0] counters_instret;

    CsrCounters #(
        .COUNTER_WIDTH (COUNTER_WIDTH))
    counters (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_instRet (i_instRet),
        .o_cycle   (counters_cycle),
        .o_instret (counters_instret));

    // Widen to 64 so the high halves read zero for narrow counters
    logic [63:0] cycleFull;
    logic [63:0] instretFull;

    assign cycleFull   = 64'(counters_cycle);
    assign instretFull = 64'(counters_instret);

    // ----------------------------------------------------------------------
    // Read mux
    // ----------------------------------------------------------------------

    Data mscratch;
    Data mtvec;
    Data mepc;
    Data oldValue;

    always_comb begin
        case (i_csr)
            CSR_MSCRATCH: oldValue = mscratch;
            CSR_MTVEC:    oldValue = mtvec;
            CSR_MEPC:     oldValue = mepc;
            CSR_CYCLE:    oldValue = cycleFull[31:0];
            CSR_CYCLEH:   oldValue = cycleFull[63:32];
            CSR_INSTRET:  oldValue = instretFull[31:0];
            CSR_INSTRETH: oldValue = instretFull[63:32];
            default:      oldValue = '0;    // Unknown address
        endcase
    end

    // ----------------------------------------------------------------------
    // Read-modify-write
    // ----------------------------------------------------------------------

    Data newValue;

    always_comb begin
        case (i_op)
            CsrOp_RW: newValue = i_data;
            CsrOp_RS: newValue = oldValue | i_data;     // Set mask bits
            CsrOp_RC: newValue = oldValue & ~i_data;    // Clear mask bits
            default:  newValue = oldValue;              // NOP keeps value
        endcase
    end

    // Only writable registers take the new value, others ignore it
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
        end
        else if (i_op != CsrOp_NOP) begin
            case (i_csr)
                CSR_MSCRATCH: mscratch <= newValue;
                CSR_MTVEC:    mtvec    <= newValue;
                CSR_MEPC:     mepc     <= newValue;
                default:      ;         // Read only or unknown
            endcase
        end
    end

    assign o_data = oldValue;   // Value before this edge

endmodule

// ==== design/csr/CsrCounters.sv ====
module CsrCounters #(
    parameter int COUNTER_WIDTH = 64)       // Counter width, 32 or 64
(
    input  logic                     i_clock,    // Clock
    input  logic                     i_reset,    // Synchronous reset
    input  logic                     i_instRet,  // One instruction retired
    output logic [COUNTER_WIDTH-1:0] o_cycle,    // Clock count
    output logic [COUNTER_WIDTH-1:0] o_instret); // Retired count

    // ----------------------------------------------------------------------
    // Counter registers
    // ----------------------------------------------------------------------

    logic [COUNTER_WIDTH-1:0] cycleCount;
    logic [COUNTER_WIDTH-1:0] instretCount;

    // Cycle counts every edge out of reset
    // Reads 0 in the first cycle after release
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            cycleCount   <= '0;
            instretCount <= '0;
        end
        else begin
            cycleCount <= cycleCount + 1'b1;    // Free running
            if (i_instRet)
                instretCount <= instretCount + 1'b1;
        end
    end

    assign o_cycle   = cycleCount;
    assign o_instret = instretCount;

endmodule

// ==== dv/StageEX_asserts.sv ====
module StageEX_asserts #(
    parameter int COUNTER_WIDTH = 64)
(
    input logic                     i_clock,
    input logic                     i_reset,
    input logic                     i_instRet,
    input Types::Data               i_dataRS2,   // Register RS2
    input Types::Data               i_storeData, // Stage o_dataB
    input logic [COUNTER_WIDTH-1:0] i_cycle,     // CsrCounters cycle
    input logic [COUNTER_WIDTH-1:0] i_instret);  // CsrCounters instret

    // Store data is a straight pass
    assert property (@(posedge i_clock) i_storeData == i_dataRS2)
        else $error("o_dataB differs from i_dataRS2");

    // One step per clock out of reset
    assert property (@(posedge i_clock) disable iff (i_reset)
        !$past(i_reset) |-> i_cycle == $past(i_cycle) + 1'b1)
        else $error("cycle counter did not advance by one");

    // No retire, no change
    assert property (@(posedge i_clock) disable iff (i_reset)
        !$past(i_reset) && !$past(i_instRet) |-> i_instret == $past(i_instret))
        else $error("instret changed without a retire pulse");

endmodule

// Counter values come from the CsrCounters instance inside the stage
bind StageEX StageEX_asserts #(
    .COUNTER_WIDTH (COUNTER_WIDTH))
asserts0 (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_instRet   (i_instRet),
    .i_dataRS2   (i_dataRS2),
    .i_storeData (o_dataB),
    .i_cycle     (csrUnit.counters.o_cycle),
    .i_instret   (csrUnit.counters.o_instret));

// ==== dv/StageEX_tb.sv ====
module StageEX_tb;

    import Types::*;

    // ----------------------------------------------------------------------
    // Run constants and DUT hookup
    // ----------------------------------------------------------------------

    localparam int          CLOCK_PERIOD  = 100;
    localparam int          RESET_CYCLES  = 16;
    localparam int          RESET_TIMEOUT = 20;           // Cycles to see counters clear
    localparam int          NUM_OPS       = 3000;
    localparam int          COUNTER_WIDTH = 64;           // DUT default
    localparam logic [31:0] SEED          = 32'hff00a390;

    logic     clock;
    logic     reset;
    logic     isValid;
    Data      instIMM;
    CSRAddr   instCSR;
    Data      dataRS1;
    Data      dataRS2;
    InstAddr  pc;
    DataASel  operandASel;
    DataBSel  operandBSel;
    ResultSel resultSel;
    AluOp     aluControl;
    CsrOp     csrControl;
    logic     instRet;
    Data      dataR;
    Data      dataB;

    StageEX dut0 (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_isValid     (isValid),
        .i_instIMM     (instIMM),
        .i_instCSR     (instCSR),
        .i_dataRS1     (dataRS1),
        .i_dataRS2     (dataRS2),
        .i_pc          (pc),
        .i_operandASel (operandASel),
        .i_operandBSel (operandBSel),
        .i_resultSel   (resultSel),
        .i_aluControl  (aluControl),
        .i_csrControl  (csrControl),
        .i_instRet     (instRet),
        .o_dataR       (dataR),
        .o_dataB       (dataB));

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    Data                      mscratch;
    Data                      mtvec;
    Data                      mepc;
    logic [COUNTER_WIDTH-1:0] cycleCount;
    logic [COUNTER_WIDTH-1:0] instretCount;
    int                       errors;
    int                       checks;

    function automatic Data pickOperandA(DataASel sel);
        case (sel)
            DataASel_RS1: return dataRS1;
            DataASel_IMM: return instIMM;
            DataASel_PC:  return pc;
            default:      return '0;            // Zero source
        endcase
    endfunction

    function automatic Data pickOperandB(DataBSel sel);
        case (sel)
            DataBSel_RS2: return dataRS2;
            DataBSel_IMM: return instIMM;
            default:      return 32'd4;         // Link offset
        endcase
    endfunction

    // RV32I integer semantics
    function automatic Data computeAlu(AluOp op, Data a, Data b);
        case (op)
            AluOp_ADD:  return a + b;
            AluOp_SUB:  return a - b;
            AluOp_SLL:  return a << b[4:0];
            AluOp_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            AluOp_SLTU: return (a < b) ? 32'd1 : 32'd0;
            AluOp_XOR:  return a ^ b;
            AluOp_SRL:  return a >> b[4:0];
            AluOp_SRA:  return Data'($signed(a) >>> b[4:0]);
            AluOp_OR:   return a | b;
            AluOp_AND:  return a & b;
            default:    return '0;
        endcase
    endfunction

    function automatic Data readCsr(CSRAddr addr);
        logic [63:0] cyc;
        logic [63:0] ret;
        cyc = 64'(cycleCount);      // High halves zero for narrow counters
        ret = 64'(instretCount);
        case (addr)
            CSR_MSCRATCH: return mscratch;
            CSR_MTVEC:    return mtvec;
            CSR_MEPC:     return mepc;
            CSR_CYCLE:    return cyc[31:0];
            CSR_CYCLEH:   return cyc[63:32];
            CSR_INSTRET:  return ret[31:0];
            CSR_INSTRETH: return ret[63:32];
            default:      return '0;            // Unknown address
        endcase
    endfunction

    // State change at a rising edge
    task automatic updateModel();
        Data opA;
        Data oldValue;
        Data newValue;
        opA      = pickOperandA(operandASel);
        oldValue = readCsr(instCSR);
        if (reset) begin
            mscratch     = '0;
            mtvec        = '0;
            mepc         = '0;
            cycleCount   = '0;
            instretCount = '0;
        end
        else begin
            cycleCount = cycleCount + 1'b1;
            if (instRet)
                instretCount = instretCount + 1'b1;
            if (isValid && csrControl != CsrOp_NOP) begin
                case (csrControl)
                    CsrOp_RW: newValue = opA;
                    CsrOp_RS: newValue = oldValue | opA;
                    default:  newValue = oldValue & ~opA;   // Clear
                endcase
                case (instCSR)
                    CSR_MSCRATCH: mscratch = newValue;
                    CSR_MTVEC:    mtvec    = newValue;
                    CSR_MEPC:     mepc     = newValue;
                    default:      ;                         // Read only or unknown
                endcase
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and checks
    // ----------------------------------------------------------------------

    task automatic driveRandom();
        int unsigned pick;
        logic [31:0] bits;
        bits        = $urandom();
        isValid     = ($urandom_range(0, 99) < 80);
        instRet     = bits[0];
        instIMM     = $urandom();
        dataRS1     = $urandom();
        dataRS2     = $urandom();
        pc          = $urandom();
        operandASel = DataASel'($urandom_range(0, 3));
        operandBSel = DataBSel'($urandom_range(0, 2));
        resultSel   = ResultSel'(bits[1]);
        aluControl  = AluOp'($urandom_range(0, 9));
        csrControl  = CsrOp'($urandom_range(0, 3));
        pick        = $urandom_range(0, 99);
        if (pick < 30) begin                   // Writable machine CSRs
            case ($urandom_range(0, 2))
                0:       instCSR = CSR_MSCRATCH;
                1:       instCSR = CSR_MTVEC;
                default: instCSR = CSR_MEPC;
            endcase
        end
        else if (pick < 60) begin              // Counters
            case ($urandom_range(0, 3))
                0:       instCSR = CSR_CYCLE;
                1:       instCSR = CSR_CYCLEH;
                2:       instCSR = CSR_INSTRET;
                default: instCSR = CSR_INSTRETH;
            endcase
        end
        else
            instCSR = CSRAddr'($urandom());    // Mostly unknown
    endtask

    task automatic checkOutputs();
        Data expectedR;
        if (resultSel == ResultSel_CSR)
            expectedR = readCsr(instCSR);
        else
            expectedR = computeAlu(aluControl, pickOperandA(operandASel),
                                   pickOperandB(operandBSel));
        checks = checks + 2;
        assert (dataR === expectedR) else begin
            $display("[ERROR] %0t o_dataR expected %h actual %h", $time, expectedR, dataR);
            errors++;
        end
        assert (dataB === dataRS2) else begin
            $display("[ERROR] %0t o_dataB expected %h actual %h", $time, dataRS2, dataB);
            errors++;
        end
    endtask

    // Entered and left at a falling edge
    task automatic runOperation();
        driveRandom();
        #(CLOCK_PERIOD / 4);                   // Mid low phase, outputs settled
        checkOutputs();
        @(posedge clock);
        updateModel();
        @(negedge clock);
    endtask

    task automatic applyReset();
        int held;
        reset      = 1'b1;
        isValid    = 1'b0;
        instRet    = 1'b0;
        csrControl = CsrOp_NOP;
        resultSel  = ResultSel_CSR;
        instCSR    = CSR_CYCLE;                // Watch the cycle counter clear
        held       = 0;
        do begin
            @(posedge clock);
            updateModel();
            @(negedge clock);
            held++;
        end while (dataR !== '0 && held < RESET_TIMEOUT);
        if (dataR !== '0) begin
            $display("Timeout: cycle counter did not clear within %0d reset cycles",
                     RESET_TIMEOUT);
            errors++;
        end
        while (held < RESET_CYCLES) begin     // Hold for the full reset length
            @(posedge clock);
            updateModel();
            @(negedge clock);
            held++;
        end
        reset = 1'b0;
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        isValid      = 1'b0;
        instIMM      = '0;
        instCSR      = '0;
        dataRS1      = '0;
        dataRS2      = '0;
        pc           = '0;
        operandASel  = DataASel_RS1;
        operandBSel  = DataBSel_RS2;
        resultSel    = ResultSel_ALU;
        aluControl   = AluOp_ADD;
        csrControl   = CsrOp_NOP;
        instRet      = 1'b0;
        mscratch     = '0;
        mtvec        = '0;
        mepc         = '0;
        cycleCount   = '0;
        instretCount = '0;
        errors       = 0;
        checks       = 0;
        void'($urandom(SEED));
        @(negedge clock);
        applyReset();
        for (int op = 0; op < NUM_OPS; op++) begin
            if (op == NUM_OPS / 2)
                applyReset();                  // Second reset mid-run
            runOperation();
        end
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
common/Types.sv
design/ALU.sv
design/csr/CsrCounters.sv
design/csr/CSRUnit.sv
design/StageEX.sv
dv/StageEX_asserts.sv
dv/StageEX_tb.sv
